//--- intr_pkg.sv
package intr_pkg;

    // Number of request lines. The 3-bit ID inside the bus byte fixes it at 8.
    localparam int NUM_SRC = 8;

    // Source identifier, one of 0 to 7.
    typedef logic [2:0] intr_id_t;

    // Operating mode held by the command decoder.
    typedef enum logic [1:0] {
        MODE_NONE = 2'b00,  // Waiting for commands.
        MODE_POLL = 2'b01,  // Round-robin scan.
        MODE_PRIO = 2'b10   // Table-ordered scan.
    } intr_mode_e;

    // Complete configuration, 26 bits.
    typedef struct packed {
        intr_mode_e                 mode;        // Active mode.
        intr_id_t [NUM_SRC-1:0]     prio_table;  // Entry 0 is the highest priority.
    } intr_cfg_t;

    // One interrupt issued by the scanner, 4 bits.
    typedef struct packed {
        logic     valid;  // Single-cycle issue strobe.
        intr_id_t id;     // Source being issued.
    } intr_req_t;

    // Command codes on bus_in[1:0].
    localparam logic [1:0] CMD_POLL = 2'b01;  // Select polling.
    localparam logic [1:0] CMD_PRIO = 2'b10;  // One word of the priority table.

    // Prefixes placed above the ID when the controller presents it.
    localparam logic [4:0] CODE_ID_POLL = 5'b01011;
    localparam logic [4:0] CODE_ID_PRIO = 5'b10011;

    // Prefixes the processor sends with the serviced ID.
    localparam logic [4:0] CODE_DONE_POLL = 5'b10100;
    localparam logic [4:0] CODE_DONE_PRIO = 5'b01100;

endpackage

//--- intr_cmd_decoder.sv
`timescale 1ns/1ps

module intr_cmd_decoder (
    input  logic                clk_in,       // System clock.
    input  logic                rst_in,       // Asynchronous reset, active high.
    input  logic [7:0]          bus_in,       // Command words from the processor.
    input  logic                proto_error,  // Bad done byte, drop the configuration.
    output intr_pkg::intr_cfg_t cfg           // Mode and priority table.
);
    import intr_pkg::*;

    intr_mode_e             mode_q;      // Current operating mode.
    intr_id_t [NUM_SRC-1:0] table_q;     // Priority table, entry 0 highest.
    logic [1:0]             word_cnt_q;  // CMD_PRIO words taken so far.
    logic                   idle;        // No mode selected, commands accepted.
    intr_id_t               slot_hi;     // Slot written from bus_in[7:5].
    intr_id_t               slot_lo;     // Slot written from bus_in[4:2].

    assign idle    = (mode_q == MODE_NONE);
    assign slot_hi = {word_cnt_q, 1'b0};  // Even slot of the pair.
    assign slot_lo = {word_cnt_q, 1'b1};  // Odd slot of the pair.

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            mode_q     <= MODE_NONE;
            table_q    <= '0;
            word_cnt_q <= '0;
        end else if (proto_error) begin
            // Error wins over any command on the bus.
            mode_q     <= MODE_NONE;
            table_q    <= '0;
            word_cnt_q <= '0;
        end else if (idle) begin
            case (bus_in[1:0])
                CMD_POLL: begin
                    mode_q     <= MODE_POLL;  // Active on the next cycle.
                    word_cnt_q <= '0;         // Drop a half-loaded table sequence.
                end
                CMD_PRIO: begin
                    // Words may arrive with gaps in between.
                    table_q[slot_hi] <= bus_in[7:5];
                    table_q[slot_lo] <= bus_in[4:2];
                    word_cnt_q       <= word_cnt_q + 2'd1;  // Wraps to 0 after the fourth.
                    if (word_cnt_q == 2'd3) begin
                        mode_q <= MODE_PRIO;  // Table complete.
                    end
                end
                default: begin
                    // Other codes are ignored.
                end
            endcase
        end
    end

    // Configuration is frozen outside MODE_NONE.
    assign cfg = '{mode: mode_q, prio_table: table_q};

endmodule

//--- intr_scanner.sv
`timescale 1ns/1ps

module intr_scanner (
    input  logic                clk_in,         // System clock.
    input  logic                rst_in,         // Asynchronous reset, active high.
    input  logic [7:0]          intr_rq,        // Request lines, active high.
    input  intr_pkg::intr_cfg_t cfg,            // Mode and priority table.
    input  logic                credit_return,  // ISR finished, credit comes back.
    input  logic                proto_error,    // Handshake failed.
    output intr_pkg::intr_req_t req             // Issue toward the handshake block.
);
    import intr_pkg::*;

    logic     credit_q;  // One interrupt may be in flight.
    intr_id_t idx_q;     // Polling position.
    logic     armed_q;   // Mode was already valid last cycle.
    logic     eval;      // Scanner evaluates this cycle.
    logic     prio_hit;  // Some table entry is active.
    intr_id_t prio_id;   // First active table entry.

    // One idle cycle after the mode turns valid.
    assign eval = armed_q && (cfg.mode != MODE_NONE);

    // Lowest table index wins, so walk from the bottom up.
    always_comb begin
        prio_hit = 1'b0;
        prio_id  = '0;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (intr_rq[cfg.prio_table[i]]) begin
                prio_hit = 1'b1;
                prio_id  = cfg.prio_table[i];
            end
        end
    end

    // Issue only while the credit is held.
    always_comb begin
        req = '0;
        if (eval && credit_q) begin
            case (cfg.mode)
                MODE_POLL: begin
                    req.valid = intr_rq[idx_q];
                    req.id    = idx_q;
                end
                MODE_PRIO: begin
                    req.valid = prio_hit;
                    req.id    = prio_id;
                end
                default: begin
                    req = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            credit_q <= 1'b1;
            idx_q    <= '0;
            armed_q  <= 1'b0;
        end else begin
            armed_q <= (cfg.mode != MODE_NONE);
            if (proto_error) begin
                credit_q <= 1'b1;  // Nothing is outstanding after an error.
                idx_q    <= '0;
            end else begin
                if (credit_return) begin
                    credit_q <= 1'b1;
                end else if (req.valid) begin
                    credit_q <= 1'b0;  // Spent in the issue cycle.
                end
                // Step past an idle source only. Without the credit the index freezes.
                if (eval && credit_q && (cfg.mode == MODE_POLL) && !intr_rq[idx_q]) begin
                    idx_q <= idx_q + 3'd1;  // 7 wraps to 0.
                end
            end
        end
    end

endmodule

//--- intr_cpu_handshake.sv
`timescale 1ns/1ps

module intr_cpu_handshake (
    input  logic                clk_in,         // System clock.
    input  logic                rst_in,         // Asynchronous reset, active high.
    input  intr_pkg::intr_req_t req,            // Issue from the scanner.
    input  intr_pkg::intr_cfg_t cfg,            // Mode selects the code set.
    input  logic                intr_in,        // Processor acknowledge, active low.
    input  logic [7:0]          bus_in,         // Done byte from the processor.
    output logic                intr_out,       // Interrupt to the processor.
    output logic                bus_oe,         // Controller drives the bus.
    output logic [7:0]          bus_out,        // Code and ID byte.
    output logic                credit_return,  // ISR done, correct byte.
    output logic                proto_error     // ISR done, wrong byte.
);
    import intr_pkg::*;

    // Processor-side phases.
    typedef enum logic [1:0] {
        IDLE      = 2'b00,  // Waiting for an issue.
        WAIT_ACK  = 2'b01,  // intr_out high, first pulse pending.
        PRESENT   = 2'b10,  // ID byte on the bus, second pulse pending.
        WAIT_DONE = 2'b11   // Bus released, done byte pending.
    } phase_e;

    phase_e     phase_q;    // Current phase.
    intr_id_t   id_q;       // Source being serviced.
    logic       ack;        // Low pulse seen on intr_in.
    logic       prio_sel;   // Priority code set in use.
    logic [4:0] id_code;    // Prefix for the presented byte.
    logic [4:0] done_code;  // Prefix the processor must return.
    logic [7:0] done_byte;  // Full expected done byte.

    assign ack       = ~intr_in;
    assign prio_sel  = (cfg.mode == MODE_PRIO);  // Mode is stable during service.
    assign id_code   = prio_sel ? CODE_ID_PRIO : CODE_ID_POLL;
    assign done_code = prio_sel ? CODE_DONE_PRIO : CODE_DONE_POLL;
    assign done_byte = {done_code, id_q};

    // Serviced ID, written only at issue.
    always_ff @(posedge clk_in) begin
        if ((phase_q == IDLE) && req.valid) begin
            id_q <= req.id;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            phase_q       <= IDLE;
            intr_out      <= 1'b0;
            bus_oe        <= 1'b0;
            bus_out       <= '0;
            credit_return <= 1'b0;
            proto_error   <= 1'b0;
        end else begin
            credit_return <= 1'b0;  // Both are one-cycle pulses.
            proto_error   <= 1'b0;
            case (phase_q)
                IDLE: begin
                    if (req.valid) begin
                        intr_out <= 1'b1;  // Rises the cycle after the issue.
                        phase_q  <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (ack) begin
                        intr_out <= 1'b0;
                        bus_out  <= {id_code, id_q};
                        bus_oe   <= 1'b1;
                        phase_q  <= PRESENT;
                    end
                end
                PRESENT: begin
                    if (ack) begin
                        bus_oe  <= 1'b0;  // Release the bus for the done byte.
                        bus_out <= '0;
                        phase_q <= WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    if (ack) begin
                        if (bus_in == done_byte) begin
                            credit_return <= 1'b1;
                        end else begin
                            proto_error <= 1'b1;  // Decoder drops the mode.
                        end
                        phase_q <= IDLE;
                    end
                end
                default: begin
                    phase_q <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- intr_ctrl_top.sv
`timescale 1ns/1ps

module intr_ctrl_top (
    input  logic       clk_in,    // System clock.
    input  logic       rst_in,    // Asynchronous reset, active high.
    input  logic [7:0] intr_rq,   // Request lines.
    input  logic [7:0] bus_in,    // Bus, processor to controller.
    input  logic       intr_in,   // Acknowledge, active low.
    output logic       intr_out,  // Interrupt to the processor.
    output logic [7:0] bus_out,   // Bus, controller to processor.
    output logic       bus_oe     // Bus direction, resolved on the board.
);
    import intr_pkg::*;

    intr_cfg_t cfg;            // Configuration from the decoder.
    intr_req_t req;            // Scanner issue.
    logic      credit_return;  // Correct done byte.
    logic      proto_error;    // Wrong done byte.

    intr_cmd_decoder u_decoder (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .bus_in      (bus_in),
        .proto_error (proto_error),
        .cfg         (cfg)
    );

    intr_scanner u_scanner (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .intr_rq       (intr_rq),
        .cfg           (cfg),
        .credit_return (credit_return),
        .proto_error   (proto_error),
        .req           (req)
    );

    intr_cpu_handshake u_handshake (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .req           (req),
        .cfg           (cfg),
        .intr_in       (intr_in),
        .bus_in        (bus_in),
        .intr_out      (intr_out),
        .bus_oe        (bus_oe),
        .bus_out       (bus_out),
        .credit_return (credit_return),
        .proto_error   (proto_error)
    );

endmodule

//--- intr_ctrl_assertions.sv
`timescale 1ns/1ps

module intr_ctrl_assertions (
    input logic       clk_in,         // System clock.
    input logic       rst_in,         // Asynchronous reset, active high.
    input logic       intr_in,        // Processor acknowledge, active low.
    input logic       intr_out,       // Interrupt to the processor.
    input logic       bus_oe,         // Controller drives the bus.
    input logic [7:0] bus_out,        // Code and ID byte.
    input logic       credit_return,  // Correct done byte.
    input logic       proto_error     // Wrong done byte.
);

    int fail_count = 0;  // Failed checks so far.

    // The ID is presented only after the interrupt is acknowledged.
    a_oe_vs_intr: assert property (@(posedge clk_in) disable iff (rst_in)
        !(bus_oe && intr_out))
        else begin
            fail_count++;
            $error("bus_oe and intr_out high in the same cycle");
        end

    // Released bus stays quiet.
    a_bus_quiet: assert property (@(posedge clk_in) disable iff (rst_in)
        !bus_oe |-> (bus_out == 8'h00))
        else begin
            fail_count++;
            $error("bus_out nonzero while bus_oe is low");
        end

    // A done result follows an acknowledge taken with the bus released.
    a_done_after_ack: assert property (@(posedge clk_in) disable iff (rst_in)
        (credit_return || proto_error) |-> $past(!intr_in && !bus_oe && !intr_out))
        else begin
            fail_count++;
            $error("done result without an acknowledge in the done phase");
        end

endmodule

bind intr_cpu_handshake intr_ctrl_assertions u_assertions (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .intr_in       (intr_in),
    .intr_out      (intr_out),
    .bus_oe        (bus_oe),
    .bus_out       (bus_out),
    .credit_return (credit_return),
    .proto_error   (proto_error)
);

//--- tb_intr_ctrl.sv
`timescale 1ns/1ps

module tb_intr_ctrl;
    import intr_pkg::*;

    localparam int CYCLE_LIMIT = 4000;  // Five tests, each well under 400 cycles.
    localparam int WAIT_LIMIT  = 64;    // Longest wait for intr_out.

    logic       clk_in = 1'b0;
    logic       rst_in;
    logic [7:0] intr_rq;
    logic [7:0] bus_in;
    logic       intr_in;
    logic       intr_out;
    logic [7:0] bus_out;
    logic       bus_oe;

    integer     seed = 80648;
    int         cycles = 0;
    int         tests = 0;
    int         failing = 0;
    int         errors = 0;
    int         test_err = 0;
    string      test_name;
    intr_id_t   prio_tbl [0:7];  // Table as loaded, entry 0 highest.
    intr_id_t   served [0:2];    // Active sources in table order.
    logic [7:0] act_mask;        // Sources raised for the priority tests.

    intr_ctrl_top u_dut (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .intr_rq  (intr_rq),
        .bus_in   (bus_in),
        .intr_in  (intr_in),
        .intr_out (intr_out),
        .bus_out  (bus_out),
        .bus_oe   (bus_oe)
    );

    always #10 clk_in = ~clk_in;  // 20 ns period.

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_id(input string what, input intr_id_t exp, input intr_id_t act);
        if (act !== exp) begin
            test_err++;
            $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            test_err++;
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            test_err++;
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err  = 0;
        tests++;
    endtask

    task automatic end_test();
        errors += test_err;
        if (test_err == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            failing++;
            $display("test %s: FAIL with %0d errors", test_name, test_err);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        rst_in  <= 1'b1;
        intr_rq <= '0;
        bus_in  <= '0;
        intr_in <= 1'b1;
        repeat (8) @(posedge clk_in);
        rst_in <= 1'b0;
    endtask

    // One command word, sampled by the decoder on the following edge.
    task automatic send_cmd(input logic [7:0] word);
        @(posedge clk_in);
        bus_in <= word;
        @(posedge clk_in);
        bus_in <= 8'h00;
    endtask

    // One-cycle low pulse on intr_in with a byte on the bus, then settle.
    task automatic pulse_ack(input logic [7:0] data);
        @(posedge clk_in);
        intr_in <= 1'b0;
        bus_in  <= data;
        @(posedge clk_in);
        intr_in <= 1'b1;
        bus_in  <= 8'h00;
        @(negedge clk_in);
    endtask

    task automatic wait_intr(output logic seen);
        int n;
        n = 0;
        @(negedge clk_in);
        while (!intr_out && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        seen = intr_out;
    endtask

    // Processor model. The ISR clears the device request before sending done.
    task automatic serve_irq(input intr_id_t exp_id, input logic [4:0] id_code,
                             input logic [7:0] done_byte, input logic drop_rq);
        logic seen;
        wait_intr(seen);
        if (!seen) begin
            test_err++;
            $display("%s: intr_out did not rise within %0d cycles", test_name, WAIT_LIMIT);
        end else begin
            pulse_ack(8'h00);
            check_flag("intr_out in present", 1'b0, intr_out);
            check_flag("bus_oe in present", 1'b1, bus_oe);
            check_byte("id byte", {id_code, exp_id}, bus_out);
            check_id("source", exp_id, bus_out[2:0]);
            if (drop_rq) begin
                @(posedge clk_in);
                intr_rq[exp_id] <= 1'b0;
            end
            pulse_ack(8'h00);
            check_flag("bus_oe after release", 1'b0, bus_oe);
            check_byte("released bus", 8'h00, bus_out);
            pulse_ack(done_byte);
        end
    endtask

    task automatic test_poll_single();
        intr_id_t id;
        begin_test("poll_single");
        apply_reset();
        id = intr_id_t'($unsigned($random(seed)) % 8);
        @(posedge clk_in);
        intr_rq[id] <= 1'b1;
        send_cmd({6'b0, CMD_POLL});
        serve_irq(id, CODE_ID_POLL, {CODE_DONE_POLL, id}, 1'b1);
        end_test();
    endtask

    task automatic test_poll_multi();
        begin_test("poll_multi");
        apply_reset();  // Index back at 0, so 2 comes before 5.
        @(posedge clk_in);
        intr_rq <= 8'b0010_0100;
        send_cmd({6'b0, CMD_POLL});
        serve_irq(3'd2, CODE_ID_POLL, {CODE_DONE_POLL, 3'd2}, 1'b1);
        serve_irq(3'd5, CODE_ID_POLL, {CODE_DONE_POLL, 3'd5}, 1'b1);
        end_test();
    endtask

    task automatic test_prio();
        int       i;
        int       j;
        int       n;
        intr_id_t tmp;
        begin_test("prio_table");
        apply_reset();
        for (i = 0; i < 8; i++) begin
            prio_tbl[i] = intr_id_t'(i);
        end
        for (i = 7; i > 0; i--) begin  // Random permutation.
            j           = $unsigned($random(seed)) % (i + 1);
            tmp         = prio_tbl[i];
            prio_tbl[i] = prio_tbl[j];
            prio_tbl[j] = tmp;
        end
        for (i = 0; i < 4; i++) begin
            send_cmd({prio_tbl[2*i], prio_tbl[2*i+1], CMD_PRIO});
        end
        act_mask = '0;
        n        = 0;
        while (n < 3) begin  // Three distinct sources.
            j = $unsigned($random(seed)) % 8;
            if (!act_mask[j]) begin
                act_mask[j] = 1'b1;
                n++;
            end
        end
        n = 0;
        for (i = 0; i < 8; i++) begin
            if (act_mask[prio_tbl[i]]) begin
                served[n] = prio_tbl[i];
                n++;
            end
        end
        @(posedge clk_in);
        intr_rq <= act_mask;
        serve_irq(served[0], CODE_ID_PRIO, {CODE_DONE_PRIO, served[0]}, 1'b1);
        end_test();
    endtask

    task automatic test_rearb();
        begin_test("rearbitration");
        serve_irq(served[1], CODE_ID_PRIO, {CODE_DONE_PRIO, served[1]}, 1'b1);
        end_test();
    endtask

    task automatic test_proto_error();
        int highs;
        begin_test("proto_error");
        // Poll prefix in priority mode is a wrong done byte. Request stays up.
        serve_irq(served[2], CODE_ID_PRIO, {CODE_DONE_POLL, served[2]}, 1'b0);
        highs = 0;
        repeat (20) begin
            @(negedge clk_in);
            if (intr_out) begin
                highs++;
            end
        end
        check_flag("intr_out while unconfigured", 1'b0, highs != 0);
        send_cmd({6'b0, CMD_POLL});
        serve_irq(served[2], CODE_ID_POLL, {CODE_DONE_POLL, served[2]}, 1'b1);
        end_test();
    endtask

    initial begin
        rst_in  = 1'b1;
        intr_rq = '0;
        bus_in  = '0;
        intr_in = 1'b1;
        test_poll_single();
        test_poll_multi();
        test_prio();
        test_rearb();
        test_proto_error();
        errors += u_dut.u_handshake.u_assertions.fail_count;
        $display("summary: %0d tests, %0d failing, %0d errors", tests, failing, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- files.f
intr_pkg.sv
intr_cmd_decoder.sv
intr_scanner.sv
intr_cpu_handshake.sv
intr_ctrl_top.sv
intr_ctrl_assertions.sv
tb_intr_ctrl.sv

//--- Bender.yml
package:
  name: intr_ctrl

sources:
  - intr_pkg.sv
  - intr_cmd_decoder.sv
  - intr_scanner.sv
  - intr_cpu_handshake.sv
  - intr_ctrl_top.sv
  - target: simulation
    files:
      - intr_ctrl_assertions.sv
      - tb_intr_ctrl.sv
